/* verilog.f */
+incdir+include
verilog/rv_pkg.sv
verilog/regfile_read_if.sv
verilog/regfile.sv
verilog/id_decoder.sv
verilog/id_stage.sv
verilog/id_top.sv
test/id_tb.sv

/* include/id_tb_cases.svh */
/* instruction table for the decode testbench
   one entry per word with its stimulus and the expected decode */

// each add_case gives pc, inst, nocmt, ack delay (ACK_RAND draws 0 to 5), operation,
// {rs1, rs2, rd}, {rs1_ren, rs2_ren, rd_wen}, op1, op2, op3 and skipcmt
task automatic load_cases();
  // add x3, x1, x2
  add_case(64'h8000_0000, 32'h0020_81b3, 1'b0, 4'd0, OP_ADD, {5'd1, 5'd2, 5'd3}, 3'b111,
           reg_init(1), reg_init(2), 64'h0, 1'b0);
  // sub x4, x6, x5
  add_case(64'h8000_0004, 32'h4053_0233, 1'b0, ACK_RAND, OP_SUB, {5'd6, 5'd5, 5'd4}, 3'b111,
           reg_init(6), reg_init(5), 64'h0, 1'b0);
  // addi x7, x8, -5
  add_case(64'h8000_0008, 32'hffb4_0393, 1'b0, 4'd2, OP_ADDI, {5'd8, 5'd0, 5'd7}, 3'b101,
           reg_init(8), 64'hffff_ffff_ffff_fffb, 64'h0, 1'b0);
  // srai x9, x10, 63
  add_case(64'h8000_000c, 32'h43f5_5493, 1'b0, ACK_RAND, OP_SRAI, {5'd10, 5'd0, 5'd9}, 3'b101,
           reg_init(10), 64'h43f, 64'h0, 1'b0);
  // ld x11, -16(x12)
  add_case(64'h8000_0010, 32'hff06_3583, 1'b0, 4'd1, OP_LD, {5'd12, 5'd0, 5'd11}, 3'b101,
           reg_init(12), 64'hffff_ffff_ffff_fff0, 64'h0, 1'b0);
  // sd x14, 40(x13)
  add_case(64'h8000_0014, 32'h02e6_b423, 1'b0, ACK_RAND, OP_SD, {5'd13, 5'd14, 5'd0}, 3'b110,
           reg_init(13), 64'h28, reg_init(14), 1'b0);
  // bne x15, x16, -8
  add_case(64'h8000_0018, 32'hff07_9ce3, 1'b0, 4'd5, OP_BNE, {5'd15, 5'd16, 5'd0}, 3'b110,
           reg_init(15), reg_init(16), 64'h8000_0010, 1'b0);
  // bgeu x17, x18, +16
  add_case(64'h8000_001c, 32'h0128_f863, 1'b0, ACK_RAND, OP_BGEU, {5'd17, 5'd18, 5'd0}, 3'b110,
           reg_init(17), reg_init(18), 64'h8000_002c, 1'b0);
  // lui x19, 0x80000
  add_case(64'h8000_0020, 32'h8000_09b7, 1'b0, 4'd0, OP_LUI, {5'd0, 5'd0, 5'd19}, 3'b001,
           64'h0, 64'hffff_ffff_8000_0000, 64'h0, 1'b0);
  // auipc x20, 0x12345
  add_case(64'h8000_0024, 32'h1234_5a17, 1'b0, 4'd3, OP_AUIPC, {5'd0, 5'd0, 5'd20}, 3'b001,
           64'h8000_0024, 64'h1234_5000, 64'h0, 1'b0);
  // jal x1, +2048
  add_case(64'h8000_0028, 32'h0010_00ef, 1'b0, ACK_RAND, OP_JAL, {5'd0, 5'd0, 5'd1}, 3'b001,
           64'h8000_0028, 64'h800, 64'h8000_002c, 1'b0);
  // jalr x5, 12(x21)
  add_case(64'h8000_002c, 32'h00ca_82e7, 1'b0, 4'd0, OP_JALR, {5'd21, 5'd0, 5'd5}, 3'b101,
           reg_init(21), 64'hc, 64'h8000_0030, 1'b0);
  // add x23, x0, x24 after a write to x0 that must not stick
  add_writeback(5'd0, 64'hffff_ffff_ffff_ffff);
  add_case(64'h8000_0030, 32'h0180_0bb3, 1'b0, 4'd1, OP_ADD, {5'd0, 5'd24, 5'd23}, 3'b111,
           64'h0, reg_init(24), 64'h0, 1'b0);
  // or x25, x22, x1 right after x22 is rewritten
  add_writeback(5'd22, 64'hdead_beef_0bad_f00d);
  add_case(64'h8000_0034, 32'h001b_6cb3, 1'b0, ACK_RAND, OP_OR, {5'd22, 5'd1, 5'd25}, 3'b111,
           64'hdead_beef_0bad_f00d, reg_init(1), 64'h0, 1'b0);
  // custom-3 word with nocmt set
  add_case(64'h8000_0038, 32'h0020_80fb, 1'b1, 4'd0, OP_NONE, 15'd0, 3'b000,
           64'h0, 64'h0, 64'h0, 1'b1);
  // mul x1, x2, x3 is outside RV64I
  add_case(64'h8000_003c, 32'h0231_00b3, 1'b0, ACK_RAND, OP_NONE, 15'd0, 3'b000,
           64'h0, 64'h0, 64'h0, 1'b0);
  add_case(64'h8000_0040, 32'hffff_ffff, 1'b1, 4'd2, OP_NONE, 15'd0, 3'b000,
           64'h0, 64'h0, 64'h0, 1'b0);
endtask

/* test/id_tb.sv */
/* decode subsystem testbench
   preloads the register file and runs the instruction table through the DUT */
`timescale 1ns/1ns
`default_nettype none
`include "rv_cfg.svh"

module id_tb import rv_pkg::*; ();

  localparam int MAX_CASES = 24;
  localparam int MAX_ACK = 5;
  localparam logic [3:0] ACK_RAND = 4'hf;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [31:0]           inst;
    logic                  nocmt;
    logic [3:0]            ack_dly;
    logic                  wb_wen;
    logic [`RV_RIDX_W-1:0] wb_rd;
    logic [`RV_XLEN-1:0]   wb_data;
    rv_decode_t            dec;
  } tb_case_t;

  logic clk;
  logic rst;
  logic i_fetched_req;
  logic i_decoded_ack;
  logic [`RV_XLEN-1:0] i_pc;
  logic [31:0] i_inst;
  logic i_nocmt;
  logic i_wb_wen;
  logic [`RV_RIDX_W-1:0] i_wb_rd;
  logic [`RV_XLEN-1:0] i_wb_data;
  logic o_decoded_req;
  logic [`RV_XLEN-1:0] o_pc;
  logic [31:0] o_inst;
  logic o_nocmt;
  logic [7:0] o_opcode;
  logic [`RV_RIDX_W-1:0] o_rs1;
  logic o_rs1_ren;
  logic [`RV_RIDX_W-1:0] o_rs2;
  logic o_rs2_ren;
  logic [`RV_RIDX_W-1:0] o_rd;
  logic o_rd_wen;
  logic [`RV_XLEN-1:0] o_op1;
  logic [`RV_XLEN-1:0] o_op2;
  logic [`RV_XLEN-1:0] o_op3;
  logic o_skipcmt;

  tb_case_t cases [MAX_CASES];
  int n_cases = 0;
  int errors = 0;
  int failed_cases = 0;
  int cycles = 0;
  int timeout_limit = 0;
  integer seed;

  id_top id_top_i (
    .clk           (clk),
    .rst           (rst),
    .i_fetched_req (i_fetched_req),
    .i_decoded_ack (i_decoded_ack),
    .i_pc          (i_pc),
    .i_inst        (i_inst),
    .i_nocmt       (i_nocmt),
    .i_wb_wen      (i_wb_wen),
    .i_wb_rd       (i_wb_rd),
    .i_wb_data     (i_wb_data),
    .o_decoded_req (o_decoded_req),
    .o_pc          (o_pc),
    .o_inst        (o_inst),
    .o_nocmt       (o_nocmt),
    .o_opcode      (o_opcode),
    .o_rs1         (o_rs1),
    .o_rs1_ren     (o_rs1_ren),
    .o_rs2         (o_rs2),
    .o_rs2_ren     (o_rs2_ren),
    .o_rd          (o_rd),
    .o_rd_wen      (o_rd_wen),
    .o_op1         (o_op1),
    .o_op2         (o_op2),
    .o_op3         (o_op3),
    .o_skipcmt     (o_skipcmt)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (timeout_limit > 0 && cycles > timeout_limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", timeout_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // register i is preloaded with the byte value i in every lane
  function automatic logic [`RV_XLEN-1:0] reg_init(input int idx);
    reg_init = 64'h0101_0101_0101_0101 * idx;
  endfunction

  task automatic add_writeback(input logic [`RV_RIDX_W-1:0] rd, input logic [`RV_XLEN-1:0] data);
    cases[n_cases].wb_wen = 1'b1;
    cases[n_cases].wb_rd = rd;
    cases[n_cases].wb_data = data;
  endtask

  task automatic add_case(input logic [`RV_XLEN-1:0] pc, input logic [31:0] inst,
                          input logic nocmt, input logic [3:0] ack_dly, input rv_op_e op,
                          input logic [14:0] idx, input logic [2:0] ens,
                          input logic [`RV_XLEN-1:0] op1, input logic [`RV_XLEN-1:0] op2,
                          input logic [`RV_XLEN-1:0] op3, input logic skip);
    tb_case_t c;
    c = cases[n_cases];
    c.pc = pc;
    c.inst = inst;
    c.nocmt = nocmt;
    c.ack_dly = ack_dly;
    c.dec.op = op;
    {c.dec.rs1, c.dec.rs2, c.dec.rd} = idx;
    {c.dec.rs1_ren, c.dec.rs2_ren, c.dec.rd_wen} = ens;
    c.dec.op1 = op1;
    c.dec.op2 = op2;
    c.dec.op3 = op3;
    c.dec.skipcmt = skip;
    cases[n_cases] = c;
    n_cases++;
  endtask

  `include "id_tb_cases.svh"

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
                            input logic [`RV_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_decode(input string name, input rv_decode_t got, input rv_decode_t exp);
    if (got.op !== exp.op) begin
      $display("[FAIL] %0t %s.op got %s (%0d) expected %s", $time, name, got.op.name(),
               got.op, exp.op.name());
      errors++;
    end
    check_word({name, ".rs1"}, got.rs1, exp.rs1);
    check_word({name, ".rs2"}, got.rs2, exp.rs2);
    check_word({name, ".rd"}, got.rd, exp.rd);
    check_bit({name, ".rs1_ren"}, got.rs1_ren, exp.rs1_ren);
    check_bit({name, ".rs2_ren"}, got.rs2_ren, exp.rs2_ren);
    check_bit({name, ".rd_wen"}, got.rd_wen, exp.rd_wen);
    check_word({name, ".op1"}, got.op1, exp.op1);
    check_word({name, ".op2"}, got.op2, exp.op2);
    check_word({name, ".op3"}, got.op3, exp.op3);
    check_bit({name, ".skipcmt"}, got.skipcmt, exp.skipcmt);
  endtask

  function automatic rv_decode_t observed_decode();
    rv_decode_t d;
    d.op = rv_op_e'(o_opcode);
    d.rs1 = o_rs1;
    d.rs2 = o_rs2;
    d.rd = o_rd;
    d.rs1_ren = o_rs1_ren;
    d.rs2_ren = o_rs2_ren;
    d.rd_wen = o_rd_wen;
    d.op1 = o_op1;
    d.op2 = o_op2;
    d.op3 = o_op3;
    d.skipcmt = o_skipcmt;
    return d;
  endfunction

  task automatic next_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic verify_idle();
    check_bit("o_decoded_req", o_decoded_req, 1'b0);
    check_decode("o_dec", observed_decode(), '0);
    check_word("o_pc", o_pc, '0);
    check_word("o_inst", o_inst, '0);
    check_bit("o_nocmt", o_nocmt, 1'b0);
  endtask

  task automatic verify_holding(input tb_case_t c);
    check_bit("o_decoded_req", o_decoded_req, 1'b1);
    check_decode("o_dec", observed_decode(), c.dec);
    check_word("o_pc", o_pc, c.pc);
    check_word("o_inst", o_inst, c.inst);
    check_bit("o_nocmt", o_nocmt, c.nocmt);
  endtask

  // x0 gets a nonzero pattern as well and that write has to be dropped
  task automatic preload_registers();
    for (int r = 0; r < `RV_NREGS; r++) begin
      next_edge();
      i_wb_wen = 1'b1;
      i_wb_rd = r[`RV_RIDX_W-1:0];
      i_wb_data = (r == 0) ? '1 : reg_init(r);
    end
    next_edge();
    i_wb_wen = 1'b0;
  endtask

  task automatic run_case(input int n);
    tb_case_t c;
    int dly;
    int start_errors;
    c = cases[n];
    start_errors = errors;
    if (c.ack_dly == ACK_RAND) dly = $unsigned($random(seed)) % (MAX_ACK + 1);
    else dly = c.ack_dly;
    next_edge();
    if (c.wb_wen) begin
      i_wb_wen = 1'b1;
      i_wb_rd = c.wb_rd;
      i_wb_data = c.wb_data;
      next_edge();
      i_wb_wen = 1'b0;
    end
    i_fetched_req = 1'b1;
    i_pc = c.pc;
    i_inst = c.inst;
    i_nocmt = c.nocmt;
    // the decode shows only after the edge that takes the fetch
    @(negedge clk);
    verify_idle();
    next_edge();
    i_fetched_req = 1'b0;
    i_pc = '0;
    i_inst = '0;
    i_nocmt = 1'b0;
    @(negedge clk);
    verify_holding(c);
    for (int k = 0; k < dly; k++) begin
      next_edge();
      @(negedge clk);
      verify_holding(c);
    end
    next_edge();
    i_decoded_ack = 1'b1;
    @(negedge clk);
    verify_holding(c);
    next_edge();
    i_decoded_ack = 1'b0;
    @(negedge clk);
    verify_idle();
    if (errors != start_errors) failed_cases++;
    $display("case %0d pc %h inst %h ack delay %0d: %s", n, c.pc, c.inst, dly,
             (errors == start_errors) ? "ok" : "mismatch");
  endtask

  initial begin
    int start_errors;
    seed = 38;
    rst = 1'b1;
    i_fetched_req = 1'b0;
    i_decoded_ack = 1'b0;
    i_pc = '0;
    i_inst = '0;
    i_nocmt = 1'b0;
    i_wb_wen = 1'b0;
    i_wb_rd = '0;
    i_wb_data = '0;
    for (int i = 0; i < MAX_CASES; i++) begin
      cases[i] = '0;
    end
    load_cases();
    // reset, preload and per case at most fetch, writeback, ack wait, ack and idle
    timeout_limit = 4 + `RV_NREGS + 4 + n_cases * (MAX_ACK + 6);
    repeat (4) next_edge();
    rst = 1'b0;
    start_errors = errors;
    @(negedge clk);
    verify_idle();
    preload_registers();
    @(negedge clk);
    verify_idle();
    $display("reset and preload: %s", (errors == start_errors) ? "ok" : "mismatch");
    for (int n = 0; n < n_cases; n++) begin
      run_case(n);
    end
    $display("%0d cases run, %0d with mismatches, %0d failed checks", n_cases,
             failed_cases, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/id_top.sv */
/* decode subsystem top
   decode stage and register file with the decode result on flat ports */
`timescale 1ns/1ns
`default_nettype none
`include "rv_cfg.svh"

module id_top import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_fetched_req,
  input  logic                  i_decoded_ack,
  input  logic [`RV_XLEN-1:0]   i_pc,
  input  logic [31:0]           i_inst,
  input  logic                  i_nocmt,
  input  logic                  i_wb_wen,
  input  logic [`RV_RIDX_W-1:0] i_wb_rd,
  input  logic [`RV_XLEN-1:0]   i_wb_data,
  output logic                  o_decoded_req,
  output logic [`RV_XLEN-1:0]   o_pc,
  output logic [31:0]           o_inst,
  output logic                  o_nocmt,
  output logic [7:0]            o_opcode,
  output logic [`RV_RIDX_W-1:0] o_rs1,
  output logic                  o_rs1_ren,
  output logic [`RV_RIDX_W-1:0] o_rs2,
  output logic                  o_rs2_ren,
  output logic [`RV_RIDX_W-1:0] o_rd,
  output logic                  o_rd_wen,
  output logic [`RV_XLEN-1:0]   o_op1,
  output logic [`RV_XLEN-1:0]   o_op2,
  output logic [`RV_XLEN-1:0]   o_op3,
  output logic                  o_skipcmt
);

  rv_decode_t dec;

  regfile_read_if rf_if ();

  id_stage u_id_stage (
    .clk           (clk),
    .rst           (rst),
    .i_fetched_req (i_fetched_req),
    .i_decoded_ack (i_decoded_ack),
    .o_decoded_req (o_decoded_req),
    .i_pc          (i_pc),
    .i_inst        (i_inst),
    .i_nocmt       (i_nocmt),
    .rf            (rf_if.requester),
    .o_pc          (o_pc),
    .o_inst        (o_inst),
    .o_nocmt       (o_nocmt),
    .o_dec         (dec)
  );

  regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rd_port (rf_if.server),
    .i_wen   (i_wb_wen),
    .i_waddr (i_wb_rd),
    .i_wdata (i_wb_data)
  );

  assign o_opcode  = dec.op;
  assign o_rs1     = dec.rs1;
  assign o_rs1_ren = dec.rs1_ren;
  assign o_rs2     = dec.rs2;
  assign o_rs2_ren = dec.rs2_ren;
  assign o_rd      = dec.rd;
  assign o_rd_wen  = dec.rd_wen;
  assign o_op1     = dec.op1;
  assign o_op2     = dec.op2;
  assign o_op3     = dec.op3;
  assign o_skipcmt = dec.skipcmt;

endmodule

`default_nettype wire

/* verilog/id_stage.sv */
/* instruction decode stage
   holds one fetched instruction and offers its decode until acknowledged */
`timescale 1ns/1ns
`default_nettype none
`include "rv_cfg.svh"

module id_stage import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_fetched_req,
  input  logic                i_decoded_ack,
  output logic                o_decoded_req,
  input  logic [`RV_XLEN-1:0] i_pc,
  input  logic [31:0]         i_inst,
  input  logic                i_nocmt,
  regfile_read_if.requester   rf,
  output logic [`RV_XLEN-1:0] o_pc,
  output logic [31:0]         o_inst,
  output logic                o_nocmt,
  output rv_decode_t          o_dec
);

  logic [`RV_XLEN-1:0] pc_q;
  rv_inst_u            inst_q;
  logic                nocmt_q;
  rv_decode_t          dec;

  // a new instruction wins over the acknowledge in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      o_decoded_req <= 1'b0;
    end else if (i_fetched_req) begin
      o_decoded_req <= 1'b1;
    end else if (i_decoded_ack) begin
      o_decoded_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched_req) begin
      pc_q    <= i_pc;
      inst_q  <= i_inst;
      nocmt_q <= i_nocmt;
    end
  end

  id_decoder u_id_decoder (
    .i_inst     (inst_q),
    .i_pc       (pc_q),
    .i_rs1_data (rf.rs1_data),
    .i_rs2_data (rf.rs2_data),
    .o_dec      (dec)
  );

  assign rf.rs1_ren = o_decoded_req & dec.rs1_ren;
  assign rf.rs2_ren = o_decoded_req & dec.rs2_ren;
  assign rf.rs1_idx = o_decoded_req ? dec.rs1 : '0;
  assign rf.rs2_idx = o_decoded_req ? dec.rs2 : '0;

  // nothing leaves the stage while it is empty
  assign o_pc    = o_decoded_req ? pc_q : '0;
  assign o_inst  = o_decoded_req ? inst_q : '0;
  assign o_nocmt = o_decoded_req & nocmt_q;
  assign o_dec   = o_decoded_req ? dec : '0;

endmodule

`default_nettype wire

/* verilog/id_decoder.sv */
/* rv64i instruction decoder
   maps one word to an operation, register usage and three operands */
`timescale 1ns/1ns
`default_nettype none
`include "rv_cfg.svh"

module id_decoder import rv_pkg::*; (
  input  rv_inst_u            i_inst,
  input  logic [`RV_XLEN-1:0] i_pc,
  input  logic [`RV_XLEN-1:0] i_rs1_data,
  input  logic [`RV_XLEN-1:0] i_rs2_data,
  output rv_decode_t          o_dec
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMMW = 7'b0011011;
  localparam logic [6:0] OPC_OPW    = 7'b0111011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [9:0]          fn_r;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] pc_plus4;
  rv_op_e              op;
  logic                use_rs1;
  logic                use_rs2;
  logic                use_rd;
  logic                legal;
  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;
  logic [`RV_XLEN-1:0] op3;

  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.r.funct3;
  assign fn_r   = {i_inst.r.funct7, i_inst.r.funct3};

  assign imm_i = {{52{i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_s = {{52{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
  assign imm_b = {{51{i_inst.b.imm12}}, i_inst.b.imm12, i_inst.b.imm11,
                  i_inst.b.imm10_5, i_inst.b.imm4_1, 1'b0};
  assign imm_u = {{32{i_inst.u.imm[19]}}, i_inst.u.imm, 12'b0};
  assign imm_j = {{43{i_inst.j.imm20}}, i_inst.j.imm20, i_inst.j.imm19_12,
                  i_inst.j.imm11, i_inst.j.imm10_1, 1'b0};
  assign pc_plus4 = i_pc + `RV_XLEN'd4;

  always_comb begin
    op      = OP_NONE;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    op1     = i_rs1_data;
    op2     = imm_i;
    op3     = '0;
    case (opcode)
      OPC_LUI: begin
        op     = OP_LUI;
        use_rd = 1'b1;
        op1    = '0;
        op2    = imm_u;
      end
      OPC_AUIPC: begin
        op     = OP_AUIPC;
        use_rd = 1'b1;
        op1    = i_pc;
        op2    = imm_u;
      end
      OPC_JAL: begin
        op     = OP_JAL;
        use_rd = 1'b1;
        op1    = i_pc;
        op2    = imm_j;
        op3    = pc_plus4;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) op = OP_JALR;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
        op3     = pc_plus4;
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  op = OP_BEQ;
          3'b001:  op = OP_BNE;
          3'b100:  op = OP_BLT;
          3'b101:  op = OP_BGE;
          3'b110:  op = OP_BLTU;
          3'b111:  op = OP_BGEU;
          default: op = OP_NONE;
        endcase
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        op2     = i_rs2_data;
        op3     = i_pc + imm_b;
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000:  op = OP_LB;
          3'b001:  op = OP_LH;
          3'b010:  op = OP_LW;
          3'b011:  op = OP_LD;
          3'b100:  op = OP_LBU;
          3'b101:  op = OP_LHU;
          3'b110:  op = OP_LWU;
          default: op = OP_NONE;
        endcase
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  op = OP_SB;
          3'b001:  op = OP_SH;
          3'b010:  op = OP_SW;
          3'b011:  op = OP_SD;
          default: op = OP_NONE;
        endcase
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        op2     = imm_s;
        op3     = i_rs2_data;
      end
      OPC_OPIMM: begin
        case (funct3)
          3'b000:  op = OP_ADDI;
          3'b010:  op = OP_SLTI;
          3'b011:  op = OP_SLTIU;
          3'b100:  op = OP_XORI;
          3'b110:  op = OP_ORI;
          3'b111:  op = OP_ANDI;
          // rv64 shifts carry a 6-bit shamt and the upper six bits pick the kind
          3'b001:  op = (i_inst.i.imm[11:6] == 6'b000000) ? OP_SLLI : OP_NONE;
          default: begin
            if (i_inst.i.imm[11:6] == 6'b000000) op = OP_SRLI;
            else if (i_inst.i.imm[11:6] == 6'b010000) op = OP_SRAI;
          end
        endcase
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_OPIMMW: begin
        case (fn_r)
          10'b0000000_001: op = OP_SLLIW;
          10'b0000000_101: op = OP_SRLIW;
          10'b0100000_101: op = OP_SRAIW;
          default:         op = (funct3 == 3'b000) ? OP_ADDIW : OP_NONE;
        endcase
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_OP: begin
        case (fn_r)
          10'b0000000_000: op = OP_ADD;
          10'b0100000_000: op = OP_SUB;
          10'b0000000_001: op = OP_SLL;
          10'b0000000_010: op = OP_SLT;
          10'b0000000_011: op = OP_SLTU;
          10'b0000000_100: op = OP_XOR;
          10'b0000000_101: op = OP_SRL;
          10'b0100000_101: op = OP_SRA;
          10'b0000000_110: op = OP_OR;
          10'b0000000_111: op = OP_AND;
          default:         op = OP_NONE;
        endcase
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
        op2     = i_rs2_data;
      end
      OPC_OPW: begin
        case (fn_r)
          10'b0000000_000: op = OP_ADDW;
          10'b0100000_000: op = OP_SUBW;
          10'b0000000_001: op = OP_SLLW;
          10'b0000000_101: op = OP_SRLW;
          10'b0100000_101: op = OP_SRAW;
          default:         op = OP_NONE;
        endcase
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
        op2     = i_rs2_data;
      end
      OPC_FENCE: begin
        if (funct3 == 3'b000) op = OP_FENCE;
      end
      OPC_SYSTEM: begin
        if (i_inst == 32'h0000_0073) op = OP_ECALL;
        else if (i_inst == 32'h0010_0073) op = OP_EBREAK;
      end
      default: op = OP_NONE;
    endcase
  end

  // an unknown encoding collapses to an all-zero result
  assign legal = (op != OP_NONE);

  always_comb begin
    o_dec         = '0;
    o_dec.op      = op;
    o_dec.rs1_ren = legal & use_rs1;
    o_dec.rs2_ren = legal & use_rs2;
    o_dec.rd_wen  = legal & use_rd;
    o_dec.rs1     = o_dec.rs1_ren ? i_inst.r.rs1 : '0;
    o_dec.rs2     = o_dec.rs2_ren ? i_inst.r.rs2 : '0;
    o_dec.rd      = o_dec.rd_wen ? i_inst.r.rd : '0;
    o_dec.op1     = legal ? op1 : '0;
    o_dec.op2     = legal ? op2 : '0;
    o_dec.op3     = legal ? op3 : '0;
    o_dec.skipcmt = (opcode == `RV_OP_SKIPCMT);
  end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
/* integer register file
   two combinational read ports, one synchronous write port, x0 reads as zero */
`timescale 1ns/1ns
`default_nettype none
`include "rv_cfg.svh"

module regfile (
  input  logic                  clk,
  input  logic                  rst,
  regfile_read_if.server        rd_port,
  input  logic                  i_wen,
  input  logic [`RV_RIDX_W-1:0] i_waddr,
  input  logic [`RV_XLEN-1:0]   i_wdata
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // x0 is never written so it keeps the value cleared at reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // reads see the array as it stands and a write lands after the edge
  always_comb begin
    if (rd_port.rs1_ren) begin
      rd_port.rs1_data = regs[rd_port.rs1_idx];
    end else begin
      rd_port.rs1_data = '0;
    end
  end

  always_comb begin
    if (rd_port.rs2_ren) begin
      rd_port.rs2_data = regs[rd_port.rs2_idx];
    end else begin
      rd_port.rs2_data = '0;
    end
  end

endmodule

`default_nettype wire

/* verilog/regfile_read_if.sv */
/* dual register file read port
   enables and indices from the requester, data back from the register file */
`timescale 1ns/1ns
`default_nettype none
`include "rv_cfg.svh"

interface regfile_read_if;

  logic                  rs1_ren;
  logic [`RV_RIDX_W-1:0] rs1_idx;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic                  rs2_ren;
  logic [`RV_RIDX_W-1:0] rs2_idx;
  logic [`RV_XLEN-1:0]   rs2_data;

  modport requester (
    output rs1_ren, rs1_idx, rs2_ren, rs2_idx,
    input  rs1_data, rs2_data
  );

  modport server (
    input  rs1_ren, rs1_idx, rs2_ren, rs2_idx,
    output rs1_data, rs2_data
  );

endinterface

`default_nettype wire

/* verilog/rv_pkg.sv */
/* rv64i decode types
   instruction format views, internal operation codes and decode result */
`default_nettype none
`include "rv_cfg.svh"

package rv_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } rv_s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_fmt_t;

  // one 32-bit word seen through each base format
  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_s_fmt_t s;
    rv_b_fmt_t b;
    rv_u_fmt_t u;
    rv_j_fmt_t j;
  } rv_inst_u;

  // OP_NONE must stay zero so an idle stage reads as no operation
  typedef enum logic [7:0] {
    OP_NONE = 8'd0,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
    OP_SB, OP_SH, OP_SW, OP_SD,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_FENCE, OP_ECALL, OP_EBREAK
  } rv_op_e;

  typedef struct packed {
    rv_op_e                  op;
    logic [`RV_RIDX_W-1:0]   rs1;
    logic [`RV_RIDX_W-1:0]   rs2;
    logic [`RV_RIDX_W-1:0]   rd;
    logic                    rs1_ren;
    logic                    rs2_ren;
    logic                    rd_wen;
    logic [`RV_XLEN-1:0]     op1;
    logic [`RV_XLEN-1:0]     op2;
    logic [`RV_XLEN-1:0]     op3;
    logic                    skipcmt;
  } rv_decode_t;

endpackage

`default_nettype wire

/* include/rv_cfg.svh */
/* rv64 core configuration
   datapath width, register file geometry and custom opcodes */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// integer register width
`define RV_XLEN 64

// architectural register count and index width
`define RV_NREGS 32
`define RV_RIDX_W 5

// custom-3 major opcode that marks an instruction retiring without commit
`define RV_OP_SKIPCMT 7'h7b

`endif
